// ==== rtl/sha_core_pkg.sv ====
`default_nettype none

package sha_core_pkg;

    // one hash word, as it sits in RAM and in the working registers
    typedef logic [31:0] word_t;

    // word counter of the load, add and write-back phases
    typedef logic [4:0] cnt_t;

    // round index 0..63
    typedef logic [5:0] rnd_t;

    // cycle within a round, 0..6
    typedef logic [2:0] cyc_t;

    // RAM word address inside the 1k map
    typedef logic [9:0] seg_t;

    typedef enum logic [2:0] {
        PH_IDLE       = 3'd0,
        PH_LOAD_IN    = 3'd1,
        PH_ROUND      = 3'd2,
        PH_ADD_OUT    = 3'd3,
        PH_WRITE_BACK = 3'd4
    } phase_t;

    // RAM map
    // IV and K sit in the low constant area
    localparam seg_t SEG_IV  = 10'd0;
    localparam seg_t SEG_K   = 10'd8;
    // chaining state, rewritten by every block
    localparam seg_t SEG_ST  = 10'd512;
    // 16 message words followed by 48 schedule words
    localparam seg_t SEG_MSG = 10'd544;

    // round offsets with this bit set address the K table instead of the schedule
    localparam int OFF_K_BIT = 9;

    localparam int WORDS_IN     = 8;
    localparam int WORDS_OUT    = 8;
    localparam int ROUNDS       = 64;
    localparam int ROUND_CYCLES = 7;
    localparam int VREG_CNT     = 16;

endpackage

`default_nettype wire

// ==== rtl/hash_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module hash_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 cfg_firsthash,
    output logic                 busy,
    output logic                 done,
    output logic                 firsthash,
    output sha_core_pkg::phase_t phase,
    output sha_core_pkg::cnt_t   word_cnt,
    output sha_core_pkg::rnd_t   rnd,
    output sha_core_pkg::cyc_t   cyc,
    output sha_core_pkg::cyc_t   cyc_pl2,
    output logic                 in_pl1,
    output logic                 in_pl2,
    output logic                 out_pl1,
    output logic                 out_pl2,
    output logic                 round_pl2,
    output sha_core_pkg::cnt_t   word_cnt_pl1
);

    import sha_core_pkg::*;

    logic   accept;
    logic   counting;
    logic   last_word;
    logic   last_cyc;
    logic   last_rnd;
    logic   round_pl1;
    cyc_t   cyc_pl1;
    phase_t phase_nxt;

    assign accept   = start && !busy;
    assign last_cyc = cyc == cyc_t'(ROUND_CYCLES - 1);
    assign last_rnd = rnd == rnd_t'(ROUNDS - 1);
    assign counting = (phase == PH_LOAD_IN) || (phase == PH_ADD_OUT) ||
                      (phase == PH_WRITE_BACK);

    // load, add and write-back all move eight words
    assign last_word = word_cnt == cnt_t'(WORDS_IN - 1);

    assign done = (phase == PH_WRITE_BACK) && last_word;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE:       if (accept) phase_nxt = PH_LOAD_IN;
            PH_LOAD_IN:    if (last_word) phase_nxt = PH_ROUND;
            PH_ROUND:      if (last_cyc && last_rnd) phase_nxt = PH_ADD_OUT;
            PH_ADD_OUT:    if (last_word) phase_nxt = PH_WRITE_BACK;
            PH_WRITE_BACK: if (last_word) phase_nxt = PH_IDLE;
            default:       phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= PH_IDLE;
            busy      <= 1'b0;
            firsthash <= 1'b0;
            word_cnt  <= '0;
            rnd       <= '0;
            cyc       <= '0;
        end else begin
            phase <= phase_nxt;
            if (accept) begin
                busy      <= 1'b1;
                firsthash <= cfg_firsthash;
            end else if (done) begin
                busy <= 1'b0;
            end
            word_cnt <= (counting && !last_word) ? word_cnt + 5'd1 : '0;
            if (phase == PH_ROUND) begin
                cyc <= last_cyc ? '0 : cyc + 3'd1;
                if (last_cyc)
                    rnd <= last_rnd ? '0 : rnd + 6'd1;
            end else begin
                cyc <= '0;
                rnd <= '0;
            end
        end
    end

    // delayed copies match returning read data to its phase
    always_ff @(posedge clk) begin
        if (rst) begin
            in_pl1       <= 1'b0;
            in_pl2       <= 1'b0;
            out_pl1      <= 1'b0;
            out_pl2      <= 1'b0;
            round_pl1    <= 1'b0;
            round_pl2    <= 1'b0;
            cyc_pl1      <= '0;
            cyc_pl2      <= '0;
            word_cnt_pl1 <= '0;
        end else begin
            in_pl1       <= phase == PH_LOAD_IN;
            in_pl2       <= in_pl1;
            out_pl1      <= phase == PH_ADD_OUT;
            out_pl2      <= out_pl1;
            round_pl1    <= phase == PH_ROUND;
            round_pl2    <= round_pl1;
            cyc_pl1      <= cyc;
            cyc_pl2      <= cyc_pl1;
            word_cnt_pl1 <= word_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_access #(
    parameter int aw = 10
) (
    input  logic                 clk,
    input  sha_core_pkg::phase_t phase,
    input  sha_core_pkg::cnt_t   word_cnt,
    input  logic                 firsthash,
    input  sha_core_pkg::seg_t   rnd_off,
    input  logic                 rnd_wr,
    input  sha_core_pkg::word_t  rnd_wdata,
    input  sha_core_pkg::word_t  vreg_wb,
    input  sha_core_pkg::word_t  ram_rdata,
    output logic [aw-1:0]        ram_addr,
    output logic                 ram_wr,
    output sha_core_pkg::word_t  ram_wdata,
    output sha_core_pkg::word_t  rdat_reg
);

    import sha_core_pkg::*;

    logic [aw-1:0] base;
    logic [aw-1:0] offset;
    logic [aw-1:0] chain_base;

    // first block chains from the IV, later blocks from the stored state
    assign chain_base = firsthash ? aw'(SEG_IV) : aw'(SEG_ST);

    always_comb begin
        base      = '0;
        offset    = '0;
        ram_wr    = 1'b0;
        ram_wdata = '0;
        case (phase)
            PH_LOAD_IN, PH_ADD_OUT: begin
                base   = chain_base;
                offset = aw'(word_cnt);
            end
            PH_ROUND: begin
                base      = rnd_off[OFF_K_BIT] ? aw'(SEG_K) : aw'(SEG_MSG);
                offset    = aw'(rnd_off[OFF_K_BIT-1:0]);
                ram_wr    = rnd_wr;
                ram_wdata = rnd_wdata;
            end
            PH_WRITE_BACK: begin
                base      = aw'(SEG_ST);
                offset    = aw'(word_cnt);
                ram_wr    = 1'b1;
                ram_wdata = vreg_wb;
            end
            default: begin
            end
        endcase
    end

    assign ram_addr = base + offset;

    // stage 3 of the read pipeline
    always_ff @(posedge clk) begin
        rdat_reg <= ram_rdata;
    end

endmodule

`default_nettype wire

// ==== rtl/sha256_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_round (
    input  logic                                              clk,
    input  logic                                              rst,
    input  sha_core_pkg::rnd_t                                rnd,
    input  sha_core_pkg::cyc_t                                cyc,
    input  sha_core_pkg::cyc_t                                cyc_pl2,
    input  logic                                              round_pl2,
    input  sha_core_pkg::word_t                               rdat_reg,
    input  sha_core_pkg::word_t [sha_core_pkg::VREG_CNT-1:0]  vreg,
    output sha_core_pkg::seg_t                                rnd_off,
    output logic                                              rnd_wr,
    output sha_core_pkg::word_t                               rnd_wdata,
    output logic [sha_core_pkg::WORDS_IN:0]                   round_we,
    output sha_core_pkg::word_t [sha_core_pkg::WORDS_IN:0]    round_next
);

    import sha_core_pkg::*;

    // working word 8 holds the schedule accumulator
    localparam int ACC = WORDS_IN;

    function automatic word_t bsig0(input word_t x);
        return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
    endfunction

    function automatic word_t bsig1(input word_t x);
        return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
    endfunction

    function automatic word_t ssig0(input word_t x);
        return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ {3'b0, x[31:3]};
    endfunction

    function automatic word_t ssig1(input word_t x);
        return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ {10'b0, x[31:10]};
    endfunction

    function automatic word_t ch(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (~x & z);
    endfunction

    function automatic word_t maj(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (x & z) ^ (y & z);
    endfunction

    word_t a, b, c, d, e, f, g, h;
    word_t acc;
    word_t sched;
    word_t t1;
    word_t t2;

    assign a   = vreg[0];
    assign b   = vreg[1];
    assign c   = vreg[2];
    assign d   = vreg[3];
    assign e   = vreg[4];
    assign f   = vreg[5];
    assign g   = vreg[6];
    assign h   = vreg[7];
    assign acc = vreg[ACC];

    // read order per round: W[t], W[t+1], W[t+9], W[t+14], K[t], then write W[t+16]
    always_comb begin
        case (cyc)
            3'd0: rnd_off = seg_t'(rnd);
            3'd1: rnd_off = seg_t'(rnd) + 10'd1;
            3'd2: rnd_off = seg_t'(rnd) + 10'd9;
            3'd3: rnd_off = seg_t'(rnd) + 10'd14;
            3'd4: begin
                rnd_off = seg_t'(rnd);
                rnd_off[OFF_K_BIT] = 1'b1;
            end
            3'd5: rnd_off = seg_t'(rnd) + 10'd16;
            default: rnd_off = seg_t'(rnd);
        endcase
    end

    // W[t+16] only exists for the first 48 rounds
    always_ff @(posedge clk) begin
        if (rst)
            rnd_wr <= 1'b0;
        else
            rnd_wr <= (cyc == 3'd4) && (rnd < rnd_t'(ROUNDS - 16));
    end

    // W[t+14] is in the read register in cycle 5, so the last term is added on the fly
    assign sched     = acc + ssig1(rdat_reg);
    assign rnd_wdata = sched;

    // h already carries W[t]; K[t] arrives in the last cycle
    assign t1 = h + bsig1(e) + ch(e, f, g) + rdat_reg;
    assign t2 = bsig0(a) + maj(a, b, c);

    always_comb begin
        round_we   = '0;
        round_next = vreg[WORDS_IN:0];
        if (round_pl2) begin
            case (cyc_pl2)
                3'd0: begin
                    round_we[ACC]   = 1'b1;
                    round_we[7]     = 1'b1;
                    round_next[ACC] = rdat_reg;
                    round_next[7]   = h + rdat_reg;
                end
                3'd1: begin
                    round_we[ACC]   = 1'b1;
                    round_next[ACC] = acc + ssig0(rdat_reg);
                end
                3'd2: begin
                    round_we[ACC]   = 1'b1;
                    round_next[ACC] = acc + rdat_reg;
                end
                3'd3: begin
                    round_we[ACC]   = 1'b1;
                    round_next[ACC] = sched;
                end
                3'd4: begin
                    round_we[WORDS_IN-1:0] = '1;
                    round_next[0] = t1 + t2;
                    round_next[1] = a;
                    round_next[2] = b;
                    round_next[3] = c;
                    round_next[4] = d + t1;
                    round_next[5] = e;
                    round_next[6] = f;
                    round_next[7] = g;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/working_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module working_regs (
    input  logic                                              clk,
    input  logic                                              in_pl1,
    input  logic                                              in_pl2,
    input  logic                                              out_pl1,
    input  logic                                              out_pl2,
    input  logic                                              round_pl2,
    input  sha_core_pkg::cnt_t                                word_cnt_pl1,
    input  sha_core_pkg::word_t                               rdat_reg,
    input  logic [sha_core_pkg::WORDS_IN:0]                   round_we,
    input  sha_core_pkg::word_t [sha_core_pkg::WORDS_IN:0]    round_next,
    input  sha_core_pkg::cnt_t                                word_cnt,
    output sha_core_pkg::word_t [sha_core_pkg::VREG_CNT-1:0]  vreg,
    output sha_core_pkg::word_t                               vreg_wb
);

    import sha_core_pkg::*;

    logic [WORDS_IN-1:0]   walk;
    word_t [WORDS_IN:0]    word_q;

    // one-hot enable walks up one word per returning read
    // shifts every cycle, so it drains itself between phases
    always_ff @(posedge clk) begin
        walk <= {walk[WORDS_IN-2:0], (in_pl1 || out_pl1) && (word_cnt_pl1 == '0)};
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i <= WORDS_IN; i++) begin
            if (round_pl2 && round_we[i])
                word_q[i] <= round_next[i];
        end
        for (int i = 0; i < WORDS_IN; i++) begin
            if (in_pl2 && walk[i])
                word_q[i] <= rdat_reg;
            // feed-forward of the chaining value
            else if (out_pl2 && walk[i])
                word_q[i] <= word_q[i] + rdat_reg;
        end
    end

    // upper words are spare on the sha-256 path
    always_comb begin
        vreg = '0;
        vreg[WORDS_IN:0] = word_q;
    end

    assign vreg_wb = vreg[word_cnt[3:0]];

endmodule

`default_nettype wire

// ==== rtl/hashcore.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashcore #(
    parameter int aw = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                busy,
    output logic                done,
    input  logic                cfg_firsthash,
    output logic [aw-1:0]       ram_addr,
    input  sha_core_pkg::word_t ram_rdata,
    output logic                ram_wr,
    output sha_core_pkg::word_t ram_wdata
);

    import sha_core_pkg::*;

    phase_t              phase;
    cnt_t                word_cnt;
    cnt_t                word_cnt_pl1;
    rnd_t                rnd;
    cyc_t                cyc;
    cyc_t                cyc_pl2;
    logic                firsthash;
    logic                in_pl1;
    logic                in_pl2;
    logic                out_pl1;
    logic                out_pl2;
    logic                round_pl2;
    seg_t                rnd_off;
    logic                rnd_wr;
    word_t               rnd_wdata;
    word_t               rdat_reg;
    word_t               vreg_wb;
    word_t [VREG_CNT-1:0] vreg;
    logic [WORDS_IN:0]   round_we;
    word_t [WORDS_IN:0]  round_next;

    hash_sequencer u_seq (
        .clk, .rst, .start, .cfg_firsthash,
        .busy, .done, .firsthash,
        .phase, .word_cnt, .rnd, .cyc, .cyc_pl2,
        .in_pl1, .in_pl2, .out_pl1, .out_pl2, .round_pl2,
        .word_cnt_pl1
    );

    ram_access #(
        .aw (aw)
    ) u_ram (
        .clk, .phase, .word_cnt, .firsthash,
        .rnd_off, .rnd_wr, .rnd_wdata, .vreg_wb,
        .ram_rdata, .ram_addr, .ram_wr, .ram_wdata,
        .rdat_reg
    );

    sha256_round u_round (
        .clk, .rst, .rnd, .cyc, .cyc_pl2, .round_pl2,
        .rdat_reg, .vreg,
        .rnd_off, .rnd_wr, .rnd_wdata,
        .round_we, .round_next
    );

    working_regs u_regs (
        .clk, .in_pl1, .in_pl2, .out_pl1, .out_pl2, .round_pl2,
        .word_cnt_pl1, .rdat_reg, .round_we, .round_next, .word_cnt,
        .vreg, .vreg_wb
    );

endmodule

`default_nettype wire

// ==== tests/hashcore_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashcore_asserts #(
    parameter int aw = 10
) (
    input logic          clk,
    input logic          rst,
    input logic          start,
    input logic          busy,
    input logic          done,
    input logic [aw-1:0] ram_addr,
    input logic          ram_wr
);

    import sha_core_pkg::*;

    // load, 64 rounds of 7 cycles, add and write back
    localparam int RUN_CYCLES = 472;

    int   fail_cnt = 0;
    int   run_cnt;
    logic in_state;
    logic in_sched;

    // cycles since the accepting edge counted while busy
    always_ff @(posedge clk) begin
        if (rst)
            run_cnt <= 0;
        else if (start && !busy)
            run_cnt <= 1;
        else if (busy)
            run_cnt <= run_cnt + 1;
    end

    assign in_state = (int'(ram_addr) >= int'(SEG_ST)) &&
                      (int'(ram_addr) < int'(SEG_ST) + WORDS_OUT);
    // only the expanded schedule words 16..63 may be written
    assign in_sched = (int'(ram_addr) >= int'(SEG_MSG) + 16) &&
                      (int'(ram_addr) < int'(SEG_MSG) + ROUNDS);

    idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !done && !ram_wr)
        else begin
            $error("done or ram_wr high while the core is idle");
            fail_cnt++;
        end

    busy_hold: assert property (@(posedge clk) disable iff (rst)
        (!busy && !start) |=> !busy)
        else begin
            $error("busy rose without a start");
            fail_cnt++;
        end

    busy_rise: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
        else begin
            $error("busy did not rise after an accepted start");
            fail_cnt++;
        end

    run_length: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |-> ##RUN_CYCLES done)
        else begin
            $error("done missing 472 cycles after start");
            fail_cnt++;
        end

    no_early_done: assert property (@(posedge clk) disable iff (rst)
        done |-> busy && (run_cnt == RUN_CYCLES))
        else begin
            $error("done at the wrong cycle of the run");
            fail_cnt++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done && !busy)
        else begin
            $error("done longer than one cycle or busy still high");
            fail_cnt++;
        end

    write_range: assert property (@(posedge clk) disable iff (rst)
        ram_wr |-> in_state || in_sched)
        else begin
            $error("RAM write outside state and schedule area");
            fail_cnt++;
        end

endmodule

bind hashcore hashcore_asserts #(
    .aw (aw)
) u_asserts (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .ram_addr (ram_addr),
    .ram_wr   (ram_wr)
);

`default_nettype wire

// ==== tests/hashcore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hashcore_tb;

    import sha_core_pkg::*;

    localparam int AW         = 10;
    localparam int RUN_CYCLES = 472;
    localparam int BLOCKS     = 3;
    localparam int MAX_CYCLES = BLOCKS * RUN_CYCLES + 584;

    localparam logic [31:0] K_TAB [0:63] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    localparam logic [31:0] IV_TAB [0:7] = '{
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    // published SHA-256 digest of abc
    localparam logic [31:0] ABC_DIGEST [0:7] = '{
        32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
        32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
    };

    logic          clk;
    logic          rst;
    logic          start;
    logic          cfg_firsthash;
    logic          busy;
    logic          done;
    logic [AW-1:0] ram_addr;
    logic [31:0]   ram_rdata;
    logic          ram_wr;
    logic [31:0]   ram_wdata;

    logic [31:0]   mem [0:1023];
    logic [AW-1:0] rd_addr;
    logic [31:0]   blk [0:15];
    logic [31:0]   exp_st [0:7];
    int            mismatch_cnt = 0;
    int            other_cnt = 0;
    int            cycle_cnt = 0;
    int            busy_after;

    hashcore #(
        .aw (AW)
    ) uut (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .cfg_firsthash (cfg_firsthash),
        .ram_addr      (ram_addr),
        .ram_rdata     (ram_rdata),
        .ram_wr        (ram_wr),
        .ram_wdata     (ram_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RAM model writes and captures the address on the rising edge
    always @(posedge clk) begin
        if (ram_wr)
            mem[ram_addr] <= ram_wdata;
        rd_addr <= ram_addr;
    end

    // read word shows up half a cycle later ahead of the next edge
    always @(negedge clk) begin
        ram_rdata <= mem[rd_addr];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    // reference compression of blk on the chaining value in exp_st
    task automatic compress_block();
        logic [31:0] w [0:63];
        logic [31:0] v [0:7];
        logic [31:0] s0;
        logic [31:0] s1;
        logic [31:0] t1;
        logic [31:0] t2;
        for (int t = 0; t < 16; t++)
            w[t] = blk[t];
        for (int t = 16; t < 64; t++) begin
            s0 = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
            s1 = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
            w[t] = w[t-16] + s0 + w[t-7] + s1;
        end
        for (int i = 0; i < 8; i++)
            v[i] = exp_st[i];
        for (int t = 0; t < 64; t++) begin
            t1 = v[7] + (rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25))
                 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + K_TAB[t] + w[t];
            t2 = (rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22))
                 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
            for (int i = 7; i > 0; i--)
                v[i] = v[i-1];
            v[4] = v[4] + t1;
            v[0] = t1 + t2;
        end
        for (int i = 0; i < 8; i++)
            exp_st[i] = exp_st[i] + v[i];
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 1024; a++)
            mem[a] = 32'h5a3c0000 ^ (a * 32'h00010001);
        for (int i = 0; i < 64; i++)
            mem[int'(SEG_K) + i] = K_TAB[i];
        for (int i = 0; i < 8; i++)
            mem[int'(SEG_IV) + i] = IV_TAB[i];
    endtask

    // padded abc block or sixteen random words
    task automatic load_block(input logic abc);
        for (int i = 0; i < 16; i++)
            blk[i] = abc ? 32'h0 : $urandom;
        if (abc) begin
            blk[0]  = 32'h61626380;
            blk[15] = 32'h00000018;
        end
        for (int i = 0; i < 16; i++)
            mem[int'(SEG_MSG) + i] = blk[i];
    endtask

    task automatic start_run(input logic first);
        start         = 1'b1;
        cfg_firsthash = first;
        @(negedge clk);
        start         = 1'b0;
        cfg_firsthash = 1'b0;
    endtask

    // returns on the falling edge after the last state write
    task automatic wait_done();
        while (!done)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic check_state(input int blk_no);
        for (int i = 0; i < 8; i++) begin
            assert (mem[int'(SEG_ST) + i] === exp_st[i])
            else begin
                $display("Mismatch at %0t ns: block %0d state word %0d got %08h expected %08h",
                         $time, blk_no, i, mem[int'(SEG_ST) + i], exp_st[i]);
                mismatch_cnt++;
            end
        end
    endtask

    task automatic check_digest();
        for (int i = 0; i < 8; i++) begin
            assert (mem[int'(SEG_ST) + i] === ABC_DIGEST[i])
            else begin
                $display("Mismatch at %0t ns: abc digest word %0d got %08h expected %08h",
                         $time, i, mem[int'(SEG_ST) + i], ABC_DIGEST[i]);
                mismatch_cnt++;
            end
        end
    endtask

    initial begin
        void'($urandom(38280));
        rst           = 1'b1;
        start         = 1'b0;
        cfg_firsthash = 1'b0;
        ram_rdata     = '0;
        rd_addr       = '0;
        fill_memory();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // idle stretch before the first start
        repeat (6) @(negedge clk);

        load_block(1'b1);
        for (int i = 0; i < 8; i++)
            exp_st[i] = IV_TAB[i];
        compress_block();
        start_run(1'b1);
        wait_done();
        check_state(1);
        check_digest();

        // chained block on top of the stored state
        load_block(1'b0);
        compress_block();
        start_run(1'b0);
        wait_done();
        check_state(2);

        // extra start in the middle of the run with the IV select set
        load_block(1'b0);
        compress_block();
        start_run(1'b0);
        repeat (100) @(negedge clk);
        start_run(1'b1);
        wait_done();
        check_state(3);

        busy_after = 0;
        repeat (16) begin
            @(negedge clk);
            if (busy)
                busy_after++;
        end
        assert (busy_after == 0)
        else begin
            $display("core started another run after the third block without a start");
            other_cnt++;
        end

        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_cnt, other_cnt, uut.u_asserts.fail_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/sha_core_pkg.sv
rtl/hash_sequencer.sv
rtl/ram_access.sv
rtl/sha256_round.sv
rtl/working_regs.sv
rtl/hashcore.sv
tests/hashcore_asserts.sv
tests/hashcore_tb.sv

// ==== Bender.yml ====
package:
  name: hashcore

sources:
  - files:
      - rtl/sha_core_pkg.sv
      - rtl/hash_sequencer.sv
      - rtl/ram_access.sv
      - rtl/sha256_round.sv
      - rtl/working_regs.sv
      - rtl/hashcore.sv
  - target: test
    files:
      - tests/hashcore_asserts.sv
      - tests/hashcore_tb.sv
